// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Control-flow kinds
    ////////////////////////////////////////////////////////////////////////////

    // Kind of control transfer reported by decode and execute
    typedef enum logic [1:0] {
        PC_NEXT   = 2'b00,
        PC_JUMP   = 2'b01,
        PC_BRANCH = 2'b10,
        PC_MRET   = 2'b11
    } pc_source_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch widths and constants
    ////////////////////////////////////////////////////////////////////////////

    // Address and data word width
    localparam int unsigned XLEN = 32;

    // Boot address is given in words, two low bits are implied zero
    localparam int unsigned BOOT_ADDR_W = 30;

    // PC increments in bytes
    localparam logic [XLEN-1:0] ILEN_FULL = 32'd4;
    localparam logic [XLEN-1:0] ILEN_COMP = 32'd2;

    // Every fetch reads the whole word
    localparam logic [3:0] FULL_BE = 4'b1111;

endpackage

`default_nettype wire

// ==== design/pc_controller.sv ====
`default_nettype none

module pc_controller (
    // Current fetch address and the response that belongs to it
    input  logic [fetch_pkg::XLEN-1:0] curr_pc_i,
    input  logic                       is_compressed_i,
    input  logic                       resp_valid_i,

    // Trap and return from trap
    input  logic                       trap_id_i,
    input  logic                       trap_ex_i,
    input  logic                       is_mret_i,
    input  logic [fetch_pkg::XLEN-1:0] mtvec_i,
    input  logic [fetch_pkg::XLEN-1:0] mepc_i,

    // Jump from decode
    input  logic                       valid_id_i,
    input  fetch_pkg::pc_source_t      pc_source_id_i,
    input  logic [fetch_pkg::XLEN-1:0] jump_target_id_i,

    // Branch from execute
    input  logic                       valid_ex_i,
    input  fetch_pkg::pc_source_t      pc_source_ex_i,
    input  logic                       branch_decision_ex_i,
    input  logic [fetch_pkg::XLEN-1:0] branch_target_ex_i,

    // Next PC and its qualifiers
    output logic [fetch_pkg::XLEN-1:0] next_pc_o,
    output logic                       redirect_o,
    output logic                       pc_load_o
);

    logic                       branch_taken;
    logic                       jump_taken;
    logic [fetch_pkg::XLEN-1:0] seq_step;

    // Taken branch only counts when execute holds a valid branch
    assign branch_taken = valid_ex_i && branch_decision_ex_i
                          && (pc_source_ex_i == fetch_pkg::PC_BRANCH);

    // Jumps resolve in decode
    assign jump_taken = valid_id_i && (pc_source_id_i == fetch_pkg::PC_JUMP);

    // Sequential step follows the size of the word just fetched
    assign seq_step = is_compressed_i ? fetch_pkg::ILEN_COMP : fetch_pkg::ILEN_FULL;

    ////////////////////////////////////////////////////////////////////////////
    // Next PC selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_pc_o  = curr_pc_i;
        redirect_o = 1'b1;
        pc_load_o  = 1'b1;
        // Older stage wins, so execute goes before decode
        if (trap_ex_i) begin
            next_pc_o = mtvec_i;
        end else if (branch_taken) begin
            next_pc_o = branch_target_ex_i;
        end else if (trap_id_i) begin
            next_pc_o = mtvec_i;
        end else if (is_mret_i) begin
            next_pc_o = mepc_i;
        end else if (jump_taken) begin
            next_pc_o = jump_target_id_i;
        end else begin
            // No redirect, advance only when a word was delivered
            redirect_o = 1'b0;
            pc_load_o  = resp_valid_i;
            next_pc_o  = curr_pc_i + seq_step;
        end
    end

endmodule

`default_nettype wire

// ==== design/obi_fetch_ctrl.sv ====
`default_nettype none

module obi_fetch_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Core side
    input  logic                       issue_en_i,
    input  logic                       flush_i,
    input  logic [fetch_pkg::XLEN-1:0] addr_i,
    output logic                       resp_valid_o,
    output logic [fetch_pkg::XLEN-1:0] resp_rdata_o,

    // OBI master, read only
    output logic                       obi_req_o,
    input  logic                       obi_gnt_i,
    output logic [fetch_pkg::XLEN-1:0] obi_addr_o,
    output logic                       obi_we_o,
    output logic [3:0]                 obi_be_o,
    output logic [fetch_pkg::XLEN-1:0] obi_wdata_o,
    input  logic                       obi_rvalid_i,
    output logic                       obi_rready_o,
    input  logic [fetch_pkg::XLEN-1:0] obi_rdata_i
);

    // One state bit where low is idle and high waits for a response
    logic                       wait_resp_q;
    logic                       req_q;
    logic                       drop_q;
    logic [fetch_pkg::XLEN-1:0] addr_q;

    logic                       issue;
    logic                       granted;
    logic                       resp_done;
    logic                       drop_set;

    // New request only from idle with nothing pending
    // A redirect in this cycle would fetch a stale address
    assign issue = !wait_resp_q && !req_q && issue_en_i && !flush_i;

    assign granted   = req_q && obi_gnt_i;
    assign resp_done = wait_resp_q && obi_rvalid_i;

    // Flush hits a fetch that will still answer after this cycle
    assign drop_set = flush_i && (req_q || (wait_resp_q && !obi_rvalid_i));

    ////////////////////////////////////////////////////////////////////////////
    // Request and response tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_resp_q <= 1'b0;
            req_q       <= 1'b0;
            drop_q      <= 1'b0;
        end else begin
            // req holds until the slave grants it
            if (issue) begin
                req_q <= 1'b1;
            end else if (granted) begin
                req_q <= 1'b0;
            end
            if (granted) begin
                wait_resp_q <= 1'b1;
            end else if (resp_done) begin
                wait_resp_q <= 1'b0;
            end
            // Drop flag lives until the stale response is swallowed
            if (drop_set) begin
                drop_q <= 1'b1;
            end else if (resp_done) begin
                drop_q <= 1'b0;
            end
        end
    end

    // Address is captured once per request
    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_q <= addr_i;
        end
    end

    assign obi_req_o    = req_q;
    assign obi_addr_o   = addr_q;
    assign obi_we_o     = 1'b0;
    assign obi_be_o     = fetch_pkg::FULL_BE;
    assign obi_wdata_o  = '0;
    // Stage never back-pressures a response
    assign obi_rready_o = 1'b1;

    // Response passes straight through unless it belongs to a flushed fetch
    assign resp_valid_o = resp_done && !drop_q && !flush_i;
    assign resp_rdata_o = obi_rdata_i;

    ////////////////////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////////////////////

    a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_o && !obi_gnt_i |=> $stable(obi_addr_o));

    a_req_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_o && !obi_gnt_i |=> obi_req_o);

    // Slave must not answer without a granted request
    a_no_rvalid_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !wait_resp_q |-> !obi_rvalid_i);

    // Drop flag only stands while the flushed fetch is still in flight
    // A lingering flag would swallow the next good response
    a_drop_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        drop_q |-> (req_q || wait_resp_q));

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
`default_nettype none

module if_stage (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [fetch_pkg::BOOT_ADDR_W-1:0] boot_addr_i,

    // OBI instruction port
    output logic                              insn_obi_req_o,
    input  logic                              insn_obi_gnt_i,
    output logic [fetch_pkg::XLEN-1:0]        insn_obi_addr_o,
    output logic                              insn_obi_we_o,
    output logic [3:0]                        insn_obi_be_o,
    output logic [fetch_pkg::XLEN-1:0]        insn_obi_wdata_o,
    input  logic                              insn_obi_rvalid_i,
    output logic                              insn_obi_rready_o,
    input  logic [fetch_pkg::XLEN-1:0]        insn_obi_rdata_i,

    // To decode
    output logic [fetch_pkg::XLEN-1:0]        pc_if_o,
    output logic [fetch_pkg::XLEN-1:0]        instr_if_o,
    output logic                              valid_if_o,
    output logic                              is_compressed_if_o,

    // Control
    input  logic                              stall_if_i,
    input  logic                              trap_id_i,
    input  logic                              trap_ex_i,
    input  logic                              is_mret_i,
    input  logic [fetch_pkg::XLEN-1:0]        mtvec_i,
    input  logic [fetch_pkg::XLEN-1:0]        mepc_i,

    // Jumps and branches
    input  logic                              valid_id_i,
    input  logic                              valid_ex_i,
    input  logic [fetch_pkg::XLEN-1:0]        jump_target_id_i,
    input  logic [fetch_pkg::XLEN-1:0]        branch_target_ex_i,
    input  logic                              branch_decision_ex_i,
    input  fetch_pkg::pc_source_t             pc_source_id_i,
    input  fetch_pkg::pc_source_t             pc_source_ex_i
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] next_pc;
    logic                       redirect;
    logic                       pc_load;
    logic                       resp_valid;
    logic [fetch_pkg::XLEN-1:0] resp_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////////////

    // PC always points at the fetch in flight
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= {boot_addr_i, 2'b00};
        end else if (pc_load) begin
            pc_q <= next_pc;
        end
    end

    pc_controller u_pc_controller (
        .curr_pc_i            (pc_q),
        .is_compressed_i      (is_compressed_if_o),
        .resp_valid_i         (resp_valid),
        .trap_id_i            (trap_id_i),
        .trap_ex_i            (trap_ex_i),
        .is_mret_i            (is_mret_i),
        .mtvec_i              (mtvec_i),
        .mepc_i               (mepc_i),
        .valid_id_i           (valid_id_i),
        .pc_source_id_i       (pc_source_id_i),
        .jump_target_id_i     (jump_target_id_i),
        .valid_ex_i           (valid_ex_i),
        .pc_source_ex_i       (pc_source_ex_i),
        .branch_decision_ex_i (branch_decision_ex_i),
        .branch_target_ex_i   (branch_target_ex_i),
        .next_pc_o            (next_pc),
        .redirect_o           (redirect),
        .pc_load_o            (pc_load)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////////////////////

    // Redirect doubles as flush for any fetch in flight
    obi_fetch_ctrl u_obi_fetch_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .issue_en_i   (!stall_if_i),
        .flush_i      (redirect),
        .addr_i       (pc_q),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .obi_req_o    (insn_obi_req_o),
        .obi_gnt_i    (insn_obi_gnt_i),
        .obi_addr_o   (insn_obi_addr_o),
        .obi_we_o     (insn_obi_we_o),
        .obi_be_o     (insn_obi_be_o),
        .obi_wdata_o  (insn_obi_wdata_o),
        .obi_rvalid_i (insn_obi_rvalid_i),
        .obi_rready_o (insn_obi_rready_o),
        .obi_rdata_i  (insn_obi_rdata_i)
    );

    // Decode outputs, compressed when the low two bits are not both set
    assign pc_if_o            = pc_q;
    assign instr_if_o         = resp_rdata;
    assign valid_if_o         = resp_valid;
    assign is_compressed_if_o = ~(resp_rdata[1] & resp_rdata[0]);

    // PC may only move under a waiting request when control flow changes
    a_pc_hold_on_backpressure: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        insn_obi_req_o && !insn_obi_gnt_i && !redirect |=> $stable(pc_q));

endmodule

`default_nettype wire

// ==== sim/clk_rst_gen.sv ====
`default_nettype none

module clk_rst_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam int HALF_PERIOD = 10;
    // Reset length in clock cycles
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // Release on a rising edge like every other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_if_stage.sv ====
`default_nettype none

module tb_if_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FETCHES = 400;
    // Worst case per fetch with stall, back-pressure and flushes
    localparam int MAX_LATENCY = 12;
    localparam int TIMEOUT_CYCLES = NUM_FETCHES * MAX_LATENCY;
    localparam logic [fetch_pkg::BOOT_ADDR_W-1:0] BOOT_ADDR = 30'h0000_0400;

    logic                       clk;
    logic                       rst_n;
    // OBI port
    logic                       req;
    logic                       gnt;
    logic [fetch_pkg::XLEN-1:0] addr;
    logic                       we;
    logic [3:0]                 be;
    logic [fetch_pkg::XLEN-1:0] wdata;
    logic                       rvalid;
    logic                       rready;
    logic [fetch_pkg::XLEN-1:0] rdata;
    // Decode side
    logic [fetch_pkg::XLEN-1:0] pc_if;
    logic [fetch_pkg::XLEN-1:0] instr_if;
    logic                       valid_if;
    logic                       comp_if;
    // Control
    logic                       stall;
    logic                       trap_id;
    logic                       trap_ex;
    logic                       mret;
    logic                       valid_id;
    logic                       valid_ex;
    logic                       branch_dec;
    logic [fetch_pkg::XLEN-1:0] mtvec;
    logic [fetch_pkg::XLEN-1:0] mepc;
    logic [fetch_pkg::XLEN-1:0] jump_tgt;
    logic [fetch_pkg::XLEN-1:0] branch_tgt;
    fetch_pkg::pc_source_t      src_id;
    fetch_pkg::pc_source_t      src_ex;

    // Slave state, random source and model state
    logic [31:0]                lfsr_q;
    logic [1:0]                 gcnt;
    logic [1:0]                 rcnt;
    logic                       rsp_pending;
    logic [fetch_pkg::XLEN-1:0] rsp_addr_pend;
    logic [fetch_pkg::XLEN-1:0] rsp_addr;
    logic [fetch_pkg::XLEN-1:0] exp_pc;
    logic                       req_prev;
    logic                       gnt_prev;
    logic                       stall_prev;
    logic [fetch_pkg::XLEN-1:0] addr_prev;
    logic                       first_req_seen;
    int                         n_valid;
    int                         n_grant;
    int                         n_mismatch;
    int                         n_proto;
    int                         cycle_cnt;

    clk_rst_gen u_clk_rst_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    if_stage uut (
        .clk_i                (clk),
        .rst_n_i              (rst_n),
        .boot_addr_i          (BOOT_ADDR),
        .insn_obi_req_o       (req),
        .insn_obi_gnt_i       (gnt),
        .insn_obi_addr_o      (addr),
        .insn_obi_we_o        (we),
        .insn_obi_be_o        (be),
        .insn_obi_wdata_o     (wdata),
        .insn_obi_rvalid_i    (rvalid),
        .insn_obi_rready_o    (rready),
        .insn_obi_rdata_i     (rdata),
        .pc_if_o              (pc_if),
        .instr_if_o           (instr_if),
        .valid_if_o           (valid_if),
        .is_compressed_if_o   (comp_if),
        .stall_if_i           (stall),
        .trap_id_i            (trap_id),
        .trap_ex_i            (trap_ex),
        .is_mret_i            (mret),
        .mtvec_i              (mtvec),
        .mepc_i               (mepc),
        .valid_id_i           (valid_id),
        .valid_ex_i           (valid_ex),
        .jump_target_id_i     (jump_tgt),
        .branch_target_ex_i   (branch_tgt),
        .branch_decision_ex_i (branch_dec),
        .pc_source_id_i       (src_id),
        .pc_source_ex_i       (src_ex)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random source and memory contents
    ////////////////////////////////////////////////////////////////////////////

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Halfword aligned target in a 64 KiB window
    function automatic logic [fetch_pkg::XLEN-1:0] rand_target();
        logic [31:0] r;
        r = rand_bits(15);
        return {16'h0001, r[14:0], 1'b0};
    endfunction

    // Word seen at any halfword address
    // Its low bits give the compressed mix
    function automatic logic [fetch_pkg::XLEN-1:0] mem_word(input logic [fetch_pkg::XLEN-1:0] a);
        logic [fetch_pkg::XLEN-1:0] h;
        h = (a ^ 32'h5bd1e995) * 32'h9e3779b1;
        return h ^ {15'd0, h[31:15]};
    endfunction

    // Redirect rule with the older stage first
    // Returns whether any redirect is taken
    function automatic logic model_redirect(output logic [fetch_pkg::XLEN-1:0] tgt);
        logic br;
        logic jmp;
        br  = valid_ex && branch_dec && (src_ex == fetch_pkg::PC_BRANCH);
        jmp = valid_id && (src_id == fetch_pkg::PC_JUMP);
        tgt = trap_ex ? mtvec : br ? branch_tgt : trap_id ? mtvec : mret ? mepc : jump_tgt;
        return trap_ex || br || trap_id || mret || jmp;
    endfunction

    task automatic check_word(input string name, input logic [fetch_pkg::XLEN-1:0] exp,
                              input logic [fetch_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            n_mismatch++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus on the rising edge
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lfsr_q = 32'd80636;
        {gnt, rvalid, stall, trap_id, trap_ex, mret, valid_id, valid_ex} = '0;
        branch_dec = 1'b0;
        rdata = '0;
        mtvec = '0;
        mepc = '0;
        jump_tgt = '0;
        branch_tgt = '0;
        src_id = fetch_pkg::PC_NEXT;
        src_ex = fetch_pkg::PC_NEXT;
        {gcnt, rcnt, rsp_pending, req_prev, gnt_prev, stall_prev, first_req_seen} = '0;
        rsp_addr_pend = '0;
        rsp_addr = '0;
        addr_prev = '0;
        exp_pc = {BOOT_ADDR, 2'b00};
        {n_valid, n_grant, n_mismatch, n_proto, cycle_cnt} = '0;
    end

    always @(posedge clk) begin : drive
        logic [31:0] r;
        // Slave takes the handshake seen in the last cycle
        rvalid <= 1'b0;
        if (req_prev && gnt_prev) begin
            rsp_pending = 1'b1;
            rsp_addr_pend = addr_prev;
            r = rand_bits(2);
            rcnt = r[1:0];
        end
        if (rsp_pending && rcnt == 2'd0) begin
            rvalid <= 1'b1;
            rdata <= mem_word(rsp_addr_pend);
            rsp_addr <= rsp_addr_pend;
            rsp_pending = 1'b0;
        end else if (rsp_pending) begin
            rcnt = rcnt - 2'd1;
        end
        // Grant delay counts down only under a waiting request
        if (req_prev && !gnt_prev) begin
            gcnt = gcnt - 2'd1;
        end else begin
            r = rand_bits(2);
            gcnt = r[1:0];
        end
        gnt <= (gcnt == 2'd0);
        // Stall runs are entered rarely and left quickly
        r = rand_bits(4);
        stall <= stall ? (r[1:0] != 2'd0) : (r == 32'd0);
        trap_ex <= 1'b0;
        trap_id <= 1'b0;
        mret <= 1'b0;
        valid_id <= 1'b0;
        valid_ex <= 1'b0;
        r = rand_bits(4);
        if (rst_n && n_valid > 0 && r == 32'd0) begin
            // Several sources may pulse together and some are not taken
            r = rand_bits(8);
            trap_ex <= r[0] & r[1];
            trap_id <= r[2] & r[3];
            mret <= r[4];
            valid_id <= r[5];
            valid_ex <= r[6];
            branch_dec <= r[7];
            r = rand_bits(4);
            src_id <= fetch_pkg::pc_source_t'(r[1:0]);
            src_ex <= fetch_pkg::pc_source_t'(r[3:2]);
            mtvec <= rand_target();
            mepc <= rand_target();
            jump_tgt <= rand_target();
            branch_tgt <= rand_target();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks at the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_cycle();
        logic [fetch_pkg::XLEN-1:0] tgt;
        logic [fetch_pkg::XLEN-1:0] word;
        if (!rst_n) begin
            check_bit("req in reset", 1'b0, req);
            check_bit("valid in reset", 1'b0, valid_if);
        end else begin
            if (req && !first_req_seen) begin
                check_word("first address", {BOOT_ADDR, 2'b00}, addr);
                first_req_seen = 1'b1;
            end
            // Every request is a plain full word read
            if (req) begin
                check_bit("write enable", 1'b0, we);
                check_word("byte enable", 32'h0000_000f, {28'd0, be});
                check_word("write data", '0, wdata);
            end
            check_bit("response ready", 1'b1, rready);
            if (req && !req_prev && stall_prev) begin
                $display("A new request was issued while the stall was high");
                n_proto++;
            end
            // Back-pressure holds request and address
            if (req_prev && !gnt_prev) begin
                check_bit("held request", 1'b1, req);
                check_word("held address", addr_prev, addr);
            end
            if (model_redirect(tgt)) begin
                check_bit("flushed valid", 1'b0, valid_if);
                exp_pc = tgt;
            end else if (valid_if) begin
                word = mem_word(exp_pc);
                check_bit("valid with rvalid", 1'b1, rvalid);
                check_word("fetch address", exp_pc, rsp_addr);
                check_word("pc", exp_pc, pc_if);
                check_word("instr", word, instr_if);
                check_bit("compressed", (word[1:0] != 2'b11), comp_if);
                exp_pc = exp_pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
                n_valid++;
                if (n_valid > n_grant) begin
                    $display("More instructions were delivered than requests granted");
                    n_proto++;
                end
            end
            if (req && gnt) begin
                n_grant++;
            end
        end
        req_prev = req;
        gnt_prev = gnt;
        stall_prev = stall;
        addr_prev = addr;
    endtask

    initial begin : monitor
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_cycle();
        end
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles: %0d of %0d delivered, %0d mismatches, %0d protocol errors",
                 cycle_cnt, n_valid, NUM_FETCHES, n_mismatch, n_proto);
        $display("Test failures found");
        $finish;
    end

    initial begin : finish_run
        wait (n_valid >= NUM_FETCHES);
        @(posedge clk);
        $display("Summary: %0d delivered, %0d granted, %0d mismatches, %0d protocol errors",
                 n_valid, n_grant, n_mismatch, n_proto);
        if (n_mismatch == 0 && n_proto == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/fetch_pkg.sv
design/pc_controller.sv
design/obi_fetch_ctrl.sv
design/if_stage.sv
sim/clk_rst_gen.sv
sim/tb_if_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_if_stage -f tb.f -o tb_if_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_if_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
